//--- verification/pktgen_stim.txt
// test  cont_cycles  ovf_hold  tready_seed  exp_pkts  exp_fail  align_drop  (all hex)
// exp_pkts is a lower bound in continuous mode and an upper bound when the run fails
1 0  0 0 3 0 0
2 0  0 5 3 0 0
3 50 0 3 3 0 0
4 0  4 6 3 1 0
5 0  0 2 3 0 0
6 0  0 7 3 0 1

//--- pktgen.f
+incdir+hw
hw/pktgen_pkg.sv
hw/sync_chain.sv
hw/tx_sequencer.sv
hw/axis_beat_gen.sv
hw/pktgen_top.sv
verification/pktgen_assert.sv
verification/pktgen_tb.sv

//--- Bender.yml
package:
  name: pktgen

export_include_dirs:
  - hw

sources:
  - files:
      - hw/pktgen_pkg.sv
      - hw/sync_chain.sv
      - hw/tx_sequencer.sv
      - hw/axis_beat_gen.sv
      - hw/pktgen_top.sv
  - target: test
    files:
      - verification/pktgen_assert.sv
      - verification/pktgen_tb.sv

//--- verification/pktgen_tb.sv
`timescale 1ns/1ps

module pktgen_tb;

    localparam int PKT_SIZE = 150;
    localparam int BEATS    = (PKT_SIZE + 63) / 64;
    localparam int FIELDS   = 7;
    localparam int MAX_TEST = 12;
    localparam logic [63:0] LAST_KEEP = (64'd1 << (PKT_SIZE % 64)) - 64'd1;

    logic clk, sys_reset, send_continuous_pkts, lbus_tx_rx_restart_in;
    logic simplex_mode_rx_aligned, tx_axis_tready, tx_ovfout, tx_unfout;
    logic [511:0] cmac_m_axis_tdata, tx_axis_tdata;
    logic [63:0]  tx_axis_tkeep;
    logic ctl_tx_enable, ctl_tx_send_rfi, tx_axis_tvalid, tx_axis_tlast, tx_axis_tuser;
    logic tx_gt_locked_led, tx_busy_led, tx_done_led, tx_fail_led;

    logic [15:0]  stim [FIELDS*MAX_TEST];
    logic [15:0]  ready_seed;
    logic [31:0]  rand_state = 32'd48;
    logic [511:0] src_last;
    logic         prev_valid, prev_accept, first_run;
    int errors, tests_run, tests_ok, pkt_count, beat_in_pkt, beats_total;
    int cycles, cycle_limit;
    string wait_what = "reset";

    pktgen_top #(.PKT_NUM(3), .PKT_SIZE(PKT_SIZE)) pktgen_top_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_mismatch(input string name, input logic [511:0] exp,
                                   input logic [511:0] got);
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // source words and tready pattern
    always @(posedge clk)
    begin
        logic [511:0] word;
        for (int i = 0; i < 16; i++)
        begin
            rand_state = lcg_next(rand_state);
            word[i*32 +: 32] = rand_state;
        end
        cmac_m_axis_tdata <= word;
        rand_state = lcg_next(rand_state);
        tx_axis_tready <= (ready_seed == 0) || rand_state[16 + ready_seed[2:0]];
    end

    //////////////////////////////
    // monitor and watchdog
    //////////////////////////////

    initial
    begin
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (cycles <= cycle_limit);
        $display("run stopped after %0d cycles waiting for %s", cycles, wait_what);
        $display("TEST FAIL");
        $finish;
    end

    always @(posedge clk)
    begin
        if (!sys_reset)
        begin
            if (tx_axis_tvalid && (!prev_valid || prev_accept) && tx_axis_tdata !== src_last)
                report_mismatch("tx_axis_tdata", src_last, tx_axis_tdata);
            if (tx_axis_tuser !== 1'b0)
                report_mismatch("tx_axis_tuser", 0, tx_axis_tuser);
            if (tx_axis_tvalid && tx_axis_tready)
            begin
                beats_total++;
                if (tx_axis_tlast)
                begin
                    if (beat_in_pkt != BEATS - 1)
                        report_mismatch("beat index at tlast", BEATS - 1, beat_in_pkt);
                    if (tx_axis_tkeep !== LAST_KEEP)
                        report_mismatch("tx_axis_tkeep", LAST_KEEP, tx_axis_tkeep);
                    pkt_count++;
                    beat_in_pkt = 0;
                end
                else
                begin
                    if (beat_in_pkt >= BEATS - 1)
                        report_mismatch("tx_axis_tlast", 1, 0);
                    if (tx_axis_tkeep !== '1)
                        report_mismatch("tx_axis_tkeep", {64{1'b1}}, tx_axis_tkeep);
                    beat_in_pkt++;
                end
            end
        end
        prev_valid  = tx_axis_tvalid;
        prev_accept = tx_axis_tvalid && tx_axis_tready;
        src_last    = cmac_m_axis_tdata;
    end

    task automatic wait_accept(input logic need_last);
        wait_what = need_last ? "an accepted last beat" : "an accepted beat";
        do @(posedge clk);
        while (!(tx_axis_tvalid && tx_axis_tready && (tx_axis_tlast || !need_last)));
    endtask

    task automatic bring_up();
        wait_what = "ctl_tx_send_rfi high";
        do @(posedge clk); while (!ctl_tx_send_rfi);
        repeat (5) @(posedge clk);
        simplex_mode_rx_aligned <= 1'b1;
        wait_what = "ctl_tx_send_rfi low";
        do @(posedge clk); while (ctl_tx_send_rfi);
        if (!ctl_tx_enable)
            report_mismatch("ctl_tx_enable", 1, ctl_tx_enable);
        wait_what = "busy led";
        do @(posedge clk); while (!tx_busy_led);
        if (!tx_gt_locked_led)
            report_mismatch("tx_gt_locked_led", 1, tx_gt_locked_led);
    endtask

    task automatic run_test(input int idx);
        logic [15:0] f [FIELDS];
        int err_before;
        for (int i = 0; i < FIELDS; i++)
            f[i] = stim[idx*FIELDS + i];
        err_before = errors;
        ready_seed = f[3];
        if (!first_run)
        begin
            pkt_count   = 0;
            beat_in_pkt = 0;
            send_continuous_pkts <= (f[1] != 0);
            lbus_tx_rx_restart_in <= 1'b1;
            repeat (2) @(posedge clk);
            lbus_tx_rx_restart_in <= 1'b0;
            wait_what = "done led to clear";
            do @(posedge clk); while (tx_done_led);
            if (tx_fail_led)
                report_mismatch("tx_fail_led", 0, tx_fail_led);
        end
        first_run = 1'b0;
        if (f[1] != 0)
        begin
            repeat (f[1]) @(posedge clk);
            send_continuous_pkts <= 1'b0;
        end
        if (f[2] != 0)
        begin
            wait_accept(1'b0);
            tx_ovfout <= 1'b1;
            repeat (f[2]) @(posedge clk);
            tx_ovfout <= 1'b0;
        end
        if (f[6] != 0)
        begin
            // drop after the first packet so the packet count has moved
            wait_accept(1'b1);
            simplex_mode_rx_aligned <= 1'b0;
            repeat (9) @(posedge clk);
            if (tx_axis_tvalid)
                report_mismatch("tx_axis_tvalid", 0, tx_axis_tvalid);
            if (tx_busy_led)
                report_mismatch("tx_busy_led", 0, tx_busy_led);
            simplex_mode_rx_aligned <= 1'b1;
            pkt_count   = 0;
            beat_in_pkt = 0;
        end
        wait_what = "done led";
        do @(posedge clk); while (!tx_done_led);
        if (tx_busy_led)
            report_mismatch("tx_busy_led", 0, tx_busy_led);
        if (tx_fail_led !== f[5][0])
            report_mismatch("tx_fail_led", f[5][0], tx_fail_led);
        if (f[1] != 0)
        begin
            if (pkt_count <= f[4])
                report_problem("continuous mode sent too few packets");
        end
        else if (f[5] != 0)
        begin
            if (pkt_count >= f[4])
                report_problem("overflow did not stop the run early");
        end
        else if (pkt_count != f[4])
            report_mismatch("packet count", f[4], pkt_count);
        if (f[5] == 0 && beat_in_pkt != 0)
            report_problem("run ended inside a packet");
        tests_run++;
        if (errors == err_before)
            tests_ok++;
        $display("test %0d %s: %0d packets", f[0], (errors == err_before) ? "ok" : "failed",
                 pkt_count);
    endtask

    initial
    begin
        int n;
        sys_reset = 1'b1;
        send_continuous_pkts = 1'b0;
        lbus_tx_rx_restart_in = 1'b0;
        simplex_mode_rx_aligned = 1'b0;
        tx_axis_tready = 1'b0;
        tx_ovfout = 1'b0;
        tx_unfout = 1'b0;
        cmac_m_axis_tdata = '0;
        first_run = 1'b1;
        foreach (stim[i])
            stim[i] = '0;
        $readmemh("verification/pktgen_stim.txt", stim);
        ready_seed = stim[3];
        n = 0;
        cycle_limit = 300;
        while (n < MAX_TEST && stim[n*FIELDS] != 0)
        begin
            cycle_limit += 300 + stim[n*FIELDS + 1] + stim[n*FIELDS + 2];
            n++;
        end
        repeat (8) @(posedge clk);
        sys_reset <= 1'b0;
        bring_up();
        for (int t = 0; t < n; t++)
            run_test(t);
        $display("%0d tests, %0d ok, %0d beats, %0d errors", tests_run, tests_ok,
                 beats_total, errors);
        if (errors == 0 && n > 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verification/pktgen_assert.sv
`timescale 1ns/1ps

module pktgen_assert (
    input logic              clk,
    input logic              sys_reset,
    input logic              tvalid,
    input logic              tready,
    input pktgen_pkg::data_t tdata,
    input logic              tlast,
    input pktgen_pkg::keep_t tkeep,
    input logic              run_end
);

    // a stalled beat holds until taken or the run is cleared
    stall_hold: assert property (@(posedge clk) disable iff (sys_reset)
        tvalid && !tready |=> !tvalid || ($stable(tdata) && $stable(tlast) && $stable(tkeep)))
        else $error("beat changed while stalled");

    full_keep: assert property (@(posedge clk) disable iff (sys_reset)
        tvalid && !tlast |-> tkeep == '1)
        else $error("partial keep on a middle beat");

    run_end_src: assert property (@(posedge clk) disable iff (sys_reset)
        run_end |-> $past(tvalid && tready && tlast))
        else $error("run_end without an accepted last beat");

endmodule

bind axis_beat_gen pktgen_assert pktgen_assert_i (
    .clk(clk), .sys_reset(sys_reset), .tvalid(tvalid), .tready(tready),
    .tdata(tdata), .tlast(tlast), .tkeep(tkeep), .run_end(run_end));

//--- hw/pktgen_top.sv
`timescale 1ns/1ps
`include "pktgen_macros.svh"

module pktgen_top #(
    parameter int PKT_NUM  = 1000,
    parameter int PKT_SIZE = 522
) (
    input  logic               clk,
    input  logic               sys_reset,
    input  logic               send_continuous_pkts,
    input  logic               lbus_tx_rx_restart_in,
    input  logic               simplex_mode_rx_aligned,
    input  logic               tx_axis_tready,
    input  logic               tx_ovfout,
    input  logic               tx_unfout,
    input  pktgen_pkg::data_t  cmac_m_axis_tdata,
    output logic               ctl_tx_enable,
    output logic               ctl_tx_send_rfi,
    output logic               tx_axis_tvalid,
    output pktgen_pkg::data_t  tx_axis_tdata,
    output logic               tx_axis_tlast,
    output pktgen_pkg::keep_t  tx_axis_tkeep,
    output logic               tx_axis_tuser,
    output logic               tx_gt_locked_led,
    output logic               tx_busy_led,
    output logic               tx_done_led,
    output logic               tx_fail_led
);

    import pktgen_pkg::*;

    logic        rx_aligned_s;
    logic        ovf_s;
    logic        unf_s;
    logic        restart_s;
    logic        continuous_s;
    logic        xfer_en;
    logic        run_end;
    led_status_t status;
    led_status_t status_led;

    //////////////////////////////
    // input resync
    //////////////////////////////

    sync_chain #(.T(logic), .STAGES(1)) aligned_sync_i (
        .clk(clk), .sys_reset(sys_reset), .d(simplex_mode_rx_aligned), .q(rx_aligned_s));
    sync_chain #(.T(logic), .STAGES(1)) ovf_sync_i (
        .clk(clk), .sys_reset(sys_reset), .d(tx_ovfout), .q(ovf_s));
    sync_chain #(.T(logic), .STAGES(1)) unf_sync_i (
        .clk(clk), .sys_reset(sys_reset), .d(tx_unfout), .q(unf_s));
    sync_chain #(.T(logic), .STAGES(`PKTGEN_RESTART_STAGES)) restart_sync_i (
        .clk(clk), .sys_reset(sys_reset), .d(lbus_tx_rx_restart_in), .q(restart_s));
    sync_chain #(.T(logic), .STAGES(`PKTGEN_CONT_STAGES)) cont_sync_i (
        .clk(clk), .sys_reset(sys_reset), .d(send_continuous_pkts), .q(continuous_s));

    tx_sequencer tx_sequencer_i (
        .clk(clk), .sys_reset(sys_reset),
        .rx_aligned(rx_aligned_s), .restart(restart_s),
        .mac_ready(tx_axis_tready), .mac_ovf(ovf_s), .mac_unf(unf_s),
        .run_end(run_end), .xfer_en(xfer_en),
        .ctl_tx_enable(ctl_tx_enable), .ctl_tx_send_rfi(ctl_tx_send_rfi),
        .status(status));

    axis_beat_gen #(.PKT_NUM(PKT_NUM), .PKT_SIZE(PKT_SIZE)) axis_beat_gen_i (
        .clk(clk), .sys_reset(sys_reset),
        .xfer_en(xfer_en), .continuous(continuous_s),
        .src_data(cmac_m_axis_tdata), .tready(tx_axis_tready),
        .tvalid(tx_axis_tvalid), .tdata(tx_axis_tdata), .tlast(tx_axis_tlast),
        .tkeep(tx_axis_tkeep), .tuser(tx_axis_tuser), .run_end(run_end));

    // led delay
    sync_chain #(.T(led_status_t), .STAGES(`PKTGEN_LED_STAGES)) led_sync_i (
        .clk(clk), .sys_reset(sys_reset), .d(status), .q(status_led));

    assign tx_gt_locked_led = status_led.gt_locked;
    assign tx_busy_led      = status_led.busy;
    assign tx_done_led      = status_led.done;
    assign tx_fail_led      = status_led.fail;

endmodule

//--- hw/axis_beat_gen.sv
`timescale 1ns/1ps
`include "pktgen_macros.svh"

module axis_beat_gen #(
    parameter int PKT_NUM  = 1000,
    parameter int PKT_SIZE = 522
) (
    input  logic               clk,
    input  logic               sys_reset,
    input  logic               xfer_en,
    input  logic               continuous,
    input  pktgen_pkg::data_t  src_data,
    input  logic               tready,
    output logic               tvalid,
    output pktgen_pkg::data_t  tdata,
    output logic               tlast,
    output pktgen_pkg::keep_t  tkeep,
    output logic               tuser,
    output logic               run_end
);

    import pktgen_pkg::*;

    localparam int        TAIL_BYTES = PKT_SIZE % `PKTGEN_BEAT_BYTES;
    localparam pkt_size_t SIZE       = pkt_size_t'(PKT_SIZE);
    localparam keep_t     LAST_KEEP  = (TAIL_BYTES == 0) ? {`PKTGEN_BEAT_BYTES{1'b1}} :
        keep_t'({`PKTGEN_BEAT_BYTES{1'b1}} >> (`PKTGEN_BEAT_BYTES - TAIL_BYTES));

    pkt_size_t   rem_bytes;
    pkt_count_t  pkt_cnt;
    logic        xfer_en_q;
    logic        run_clear;
    logic        accept;
    logic        load;
    logic        beat_is_last;
    logic        pkt_start;
    logic        limit_hit;
    logic [16:0] done_pkts;

    // halt drops xfer_en for one cycle only, two low cycles mean the run is over
    assign run_clear    = !xfer_en && !xfer_en_q;
    assign accept       = tvalid && tready;
    assign beat_is_last = (rem_bytes <= pkt_size_t'(`PKTGEN_BEAT_BYTES));
    assign pkt_start    = (rem_bytes == SIZE);

    // packets finished once the beat in the register is taken
    assign done_pkts = {1'b0, pkt_cnt} + 17'(tvalid && tlast);
    assign limit_hit = pkt_start && !continuous && (done_pkts >= 17'(PKT_NUM));
    assign load      = xfer_en && (!tvalid || tready) && !limit_hit;

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            xfer_en_q <= 1'b0;
            rem_bytes <= SIZE;
            pkt_cnt   <= '0;
            tvalid    <= 1'b0;
            tlast     <= 1'b0;
            run_end   <= 1'b0;
        end
        else
        begin
            xfer_en_q <= xfer_en;
            run_end   <= accept && tlast && !continuous && (done_pkts >= 17'(PKT_NUM));
            if (run_clear)
            begin
                rem_bytes <= SIZE;
                pkt_cnt   <= '0;
                tvalid    <= 1'b0;
                tlast     <= 1'b0;
            end
            else
            begin
                if (load)
                begin
                    rem_bytes <= beat_is_last ? SIZE : rem_bytes - pkt_size_t'(`PKTGEN_BEAT_BYTES);
                    tvalid    <= 1'b1;
                    tlast     <= beat_is_last;
                end
                else if (accept)
                    tvalid <= 1'b0;
                // saturating count of accepted packets
                if (accept && tlast && pkt_cnt != '1)
                    pkt_cnt <= pkt_cnt + 1'b1;
            end
        end
    end

    // beat payload
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            tdata <= src_data;
            tkeep <= beat_is_last ? LAST_KEEP : {`PKTGEN_BEAT_BYTES{1'b1}};
        end
    end

    // a halted beat is kept, never aborted
    assign tuser = 1'b0;

endmodule

//--- hw/tx_sequencer.sv
`timescale 1ns/1ps
`include "pktgen_macros.svh"

module tx_sequencer (
    input  logic                     clk,
    input  logic                     sys_reset,
    input  logic                     rx_aligned,
    input  logic                     restart,
    input  logic                     mac_ready,
    input  logic                     mac_ovf,
    input  logic                     mac_unf,
    input  logic                     run_end,
    output logic                     xfer_en,
    output logic                     ctl_tx_enable,
    output logic                     ctl_tx_send_rfi,
    output pktgen_pkg::led_status_t  status
);

    import pktgen_pkg::*;

    localparam int INIT_W = $clog2(`PKTGEN_INIT_WAIT + 1);

    tx_state_e         state;
    tx_state_e         state_next;
    logic [INIT_W-1:0] init_cnt;
    logic              init_done;
    logic              restart_q;
    logic              restart_rise;
    logic              mac_err;
    logic              link_up;
    logic              done_q;
    logic              fail_q;

    assign mac_err      = mac_ovf || mac_unf;
    assign restart_rise = restart && !restart_q;
    assign init_done    = (init_cnt == INIT_W'(`PKTGEN_INIT_WAIT - 1));

    // states that need the receive side aligned
    assign link_up = state inside {st_xfer_init, st_xfer, st_halt, st_done, st_wait_restart};

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:         state_next = st_send_rfi;
            st_send_rfi:     state_next = st_wait_aligned;
            st_wait_aligned:
            begin
                if (rx_aligned)
                    state_next = st_xfer_init;
            end
            st_xfer_init:
            begin
                if (init_done && mac_ready && !mac_err)
                    state_next = st_xfer;
            end
            st_xfer:
            begin
                if (run_end)
                    state_next = st_done;
                else if (mac_err)
                    state_next = st_halt;
            end
            // one cycle of grace, a persisting report ends the run
            st_halt:         state_next = mac_err ? st_done : st_xfer;
            st_done:         state_next = st_wait_restart;
            st_wait_restart:
            begin
                if (restart_rise)
                    state_next = st_xfer_init;
            end
            default:         state_next = st_idle;
        endcase

        if (link_up && !rx_aligned)
            state_next = st_idle;
    end

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            state     <= st_idle;
            restart_q <= 1'b0;
            init_cnt  <= '0;
        end
        else
        begin
            state     <= state_next;
            restart_q <= restart;
            // settling count, held at its end value
            if (state != st_xfer_init)
                init_cnt <= '0;
            else if (!init_done)
                init_cnt <= init_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // done and fail latches
    //////////////////////////////

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            done_q <= 1'b0;
            fail_q <= 1'b0;
        end
        else if (state == st_wait_restart && restart_rise)
        begin
            done_q <= 1'b0;
            fail_q <= 1'b0;
        end
        else
        begin
            if (state == st_done)
                done_q <= 1'b1;
            if (state == st_halt && mac_err)
                fail_q <= 1'b1;
        end
    end

    // mac controls and led status decode
    assign xfer_en         = (state == st_xfer);
    assign ctl_tx_send_rfi = state inside {st_send_rfi, st_wait_aligned};
    assign ctl_tx_enable   = link_up;

    assign status.gt_locked = (state != st_idle);
    assign status.busy      = state inside {st_xfer_init, st_xfer, st_halt, st_done};
    assign status.done      = done_q;
    assign status.fail      = fail_q;

endmodule

//--- hw/sync_chain.sv
`timescale 1ns/1ps

module sync_chain #(
    parameter type T      = logic,
    parameter int  STAGES = 1
) (
    input  logic clk,
    input  logic sys_reset,
    input  T     d,
    output T     q
);

    T chain [STAGES];

    // plain shift chain, first stage samples the input
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            for (int i = 0; i < STAGES; i++)
            begin
                chain[i] <= '0;
            end
        end
        else
        begin
            chain[0] <= d;
            for (int i = 1; i < STAGES; i++)
            begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign q = chain[STAGES-1];

endmodule

//--- hw/pktgen_pkg.sv
`include "pktgen_macros.svh"

package pktgen_pkg;

    //////////////////////////////
    // sequencer
    //////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_send_rfi,
        st_wait_aligned,
        st_xfer_init,
        st_xfer,
        st_halt,
        st_done,
        st_wait_restart
    } tx_state_e;

    // one bit per board led
    typedef struct packed {
        logic gt_locked;
        logic busy;
        logic done;
        logic fail;
    } led_status_t;

    //////////////////////////////
    // axi-stream payload
    //////////////////////////////

    typedef logic [`PKTGEN_DATA_W-1:0]     data_t;
    typedef logic [`PKTGEN_BEAT_BYTES-1:0] keep_t;

    // packet size in bytes, packet count
    typedef logic [13:0] pkt_size_t;
    typedef logic [15:0] pkt_count_t;

endpackage

//--- hw/pktgen_macros.svh
`ifndef PKTGEN_MACROS_SVH
`define PKTGEN_MACROS_SVH

//////////////////////////////
// beat geometry
//////////////////////////////

// bytes carried by one 512-bit beat
`define PKTGEN_BEAT_BYTES 64
`define PKTGEN_DATA_W 512

//////////////////////////////
// sequencing and resync
//////////////////////////////

// settling cycles in xfer_init
`define PKTGEN_INIT_WAIT 16

// restart and continuous-mode synchroniser depths
`define PKTGEN_RESTART_STAGES 4
`define PKTGEN_CONT_STAGES 3

// led delay chain
`define PKTGEN_LED_STAGES 4

`endif
